/* ps2_pkg.sv */
package ps2_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // vector types
    // ~~~~~~~~~~~~~~~~~~~~
    typedef logic [7:0] ps2_byte_t;   // one data byte of a PS/2 frame.
    typedef logic [7:0] coord_t;      // unsigned screen coordinate.
    typedef logic [3:0] hex_digit_t;  // value of one display digit.

    // ~~~~~~~~~~~~~~~~~~~~
    // packed structs
    // ~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        ps2_byte_t data;
        logic      parity_ok;  // odd parity over data and parity bit held.
    } rx_byte_t;

    typedef struct packed {
        ps2_byte_t status;     // first byte, carries buttons and sign bits.
        ps2_byte_t dx;
        ps2_byte_t dy;
    } mouse_pkt_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   left;
        logic   right;
    } mouse_pos_t;

    // encoding goes straight to the state LEDs.
    typedef enum logic [2:0] {
        INIT_IDLE    = 3'd0,
        INIT_INHIBIT = 3'd1,
        INIT_REQUEST = 3'd2,
        INIT_SEND    = 3'd3,
        INIT_ACK_BIT = 3'd4,
        INIT_WAIT_FA = 3'd5,
        INIT_STREAM  = 3'd6
    } init_state_e;

    // ~~~~~~~~~~~~~~~~~~~~
    // protocol constants
    // ~~~~~~~~~~~~~~~~~~~~
    localparam ps2_byte_t CMD_ENABLE_STREAM = 8'hF4;
    localparam ps2_byte_t RSP_ACK           = 8'hFA;
    localparam coord_t    POS_RESET         = 8'h80;
    localparam int        FRAME_BITS        = 11;  // start, 8 data, parity, stop.

    // bit positions inside the status byte.
    localparam int STAT_LEFT    = 0;
    localparam int STAT_RIGHT   = 1;
    localparam int STAT_ALWAYS1 = 3;
    localparam int STAT_X_SIGN  = 4;
    localparam int STAT_Y_SIGN  = 5;
    localparam int STAT_X_OVF   = 6;
    localparam int STAT_Y_OVF   = 7;

endpackage

/* ps2_frame_rx.sv */
`timescale 1ns/1ns

module ps2_frame_rx (
    input  logic              CLK100_IN,
    input  logic              rst_n,
    input  logic              ps2_clk_in,
    input  logic              ps2_data_in,
    input  logic              rx_enable,
    output logic              clk_fall,
    output logic              data_sync,
    output logic              rx_valid,
    output ps2_pkg::rx_byte_t rx_byte
);

    import ps2_pkg::*;

    logic [1:0]            line_s1_q;   // {clk, data} first stage.
    logic [1:0]            line_s2_q;   // {clk, data} second stage.
    logic                  clk_prev_q;
    logic [3:0]            bit_cnt_q;
    logic [FRAME_BITS-2:0] shift_q;     // first ten bits of the frame, start bit lowest.
    logic [FRAME_BITS-1:0] frame_next;
    logic                  frame_ok;

    // ~~~~~~~~~~~~~~~~~~~~
    // line synchroniser
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge CLK100_IN or negedge rst_n) begin
        if (!rst_n) begin
            line_s1_q  <= 2'b11;                       // idle bus is high on both lines.
            line_s2_q  <= 2'b11;
            clk_prev_q <= 1'b1;
        end else begin
            line_s1_q  <= {ps2_clk_in, ps2_data_in};
            line_s2_q  <= line_s1_q;
            clk_prev_q <= line_s2_q[1];
        end
    end

    assign clk_fall  = clk_prev_q & ~line_s2_q[1];     // one cycle per falling edge.
    assign data_sync = line_s2_q[0];

    // ~~~~~~~~~~~~~~~~~~~~
    // frame shifter
    // ~~~~~~~~~~~~~~~~~~~~
    // the eleventh bit is taken straight from the line when the frame closes.
    assign frame_next = {data_sync, shift_q};
    assign frame_ok   = ~frame_next[0] & frame_next[FRAME_BITS-1];  // start 0, stop 1.

    always_ff @(posedge CLK100_IN or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt_q <= '0;
            rx_valid  <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!rx_enable) begin
                bit_cnt_q <= '0;                       // host owns the line right now.
            end else if (clk_fall) begin
                if (bit_cnt_q == 4'(FRAME_BITS - 1)) begin
                    bit_cnt_q <= '0;
                    rx_valid  <= frame_ok;             // bad framing is dropped silently.
                end else begin
                    bit_cnt_q <= bit_cnt_q + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge CLK100_IN) begin
        if (rx_enable && clk_fall) begin
            shift_q <= frame_next[FRAME_BITS-1:1];
            if (bit_cnt_q == 4'(FRAME_BITS - 1) && frame_ok) begin
                rx_byte.data      <= frame_next[8:1];
                rx_byte.parity_ok <= ^frame_next[9:1]; // odd parity holds when the xor is one.
            end
        end
    end

endmodule

/* ps2_mouse_init.sv */
`timescale 1ns/1ns

module ps2_mouse_init #(
    parameter int INHIBIT_CYCLES = 10000
) (
    input  logic                 CLK100_IN,
    input  logic                 rst_n,
    input  logic                 clk_fall,
    input  logic                 data_sync,
    input  logic                 rx_valid,
    input  ps2_pkg::rx_byte_t    rx_byte,
    output logic                 clk_drive_low,
    output logic                 data_drive_low,
    output logic                 rx_enable,
    output logic                 init_done,
    output ps2_pkg::init_state_e state
);

    import ps2_pkg::*;

    localparam int CNT_W = $clog2(INHIBIT_CYCLES + 1);

    // data bits first, parity on top, sent lsb first.
    localparam logic [8:0] TX_FRAME = {~^CMD_ENABLE_STREAM, CMD_ENABLE_STREAM};

    init_state_e      state_q;
    logic [CNT_W-1:0] inhibit_cnt_q;
    logic [3:0]       tx_cnt_q;     // index of the next bit to present.
    logic             data_low_q;

    // ~~~~~~~~~~~~~~~~~~~~
    // init FSM
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge CLK100_IN or negedge rst_n) begin
        if (!rst_n) begin
            state_q       <= INIT_IDLE;
            inhibit_cnt_q <= '0;
            tx_cnt_q      <= '0;
            data_low_q    <= 1'b0;
        end else begin
            if (state_q != INIT_INHIBIT) begin
                inhibit_cnt_q <= '0;                     // every entry starts a fresh hold.
            end
            case (state_q)
                INIT_IDLE: begin
                    state_q <= INIT_INHIBIT;
                end
                INIT_INHIBIT: begin
                    data_low_q <= 1'b0;
                    if (inhibit_cnt_q == CNT_W'(INHIBIT_CYCLES - 1)) begin
                        state_q    <= INIT_REQUEST;
                        data_low_q <= 1'b1;              // start bit, held until the first fall.
                    end else begin
                        inhibit_cnt_q <= inhibit_cnt_q + 1'b1;
                    end
                end
                INIT_REQUEST: begin
                    tx_cnt_q <= '0;
                    state_q  <= INIT_SEND;               // clock is released from here on.
                end
                INIT_SEND: begin
                    if (clk_fall) begin
                        if (tx_cnt_q == 4'd9) begin
                            data_low_q <= 1'b0;          // released line is the stop bit.
                            state_q    <= INIT_ACK_BIT;
                        end else begin
                            data_low_q <= ~TX_FRAME[tx_cnt_q];
                            tx_cnt_q   <= tx_cnt_q + 4'd1;
                        end
                    end
                end
                INIT_ACK_BIT: begin
                    if (clk_fall) begin
                        // the mouse pulls data low to acknowledge.
                        state_q <= data_sync ? INIT_INHIBIT : INIT_WAIT_FA;
                    end
                end
                INIT_WAIT_FA: begin
                    if (rx_valid) begin
                        if (rx_byte.parity_ok && rx_byte.data == RSP_ACK) begin
                            state_q <= INIT_STREAM;
                        end else begin
                            state_q <= INIT_INHIBIT;     // anything else restarts the command.
                        end
                    end
                end
                INIT_STREAM: begin
                    state_q <= INIT_STREAM;
                end
                default: begin
                    state_q <= INIT_IDLE;
                end
            endcase
        end
    end

    assign clk_drive_low  = (state_q == INIT_INHIBIT) || (state_q == INIT_REQUEST);
    assign data_drive_low = data_low_q;
    assign rx_enable      = (state_q == INIT_WAIT_FA) || (state_q == INIT_STREAM);
    assign init_done      = (state_q == INIT_STREAM);
    assign state          = state_q;

endmodule

/* ps2_packet_asm.sv */
`timescale 1ns/1ns

module ps2_packet_asm (
    input  logic                CLK100_IN,
    input  logic                rst_n,
    input  logic                init_done,
    input  logic                rx_valid,
    input  ps2_pkg::rx_byte_t   rx_byte,
    output logic                pkt_valid,
    output ps2_pkg::mouse_pkt_t pkt
);

    import ps2_pkg::*;

    logic [1:0] idx_q;       // which packet byte is expected next.
    ps2_byte_t  status_q;
    ps2_byte_t  dx_q;
    logic       accept;

    assign accept = init_done & rx_valid & rx_byte.parity_ok;

    always_ff @(posedge CLK100_IN or negedge rst_n) begin
        if (!rst_n) begin
            idx_q     <= 2'd0;
            pkt_valid <= 1'b0;
        end else begin
            pkt_valid <= 1'b0;
            if (!init_done) begin
                idx_q <= 2'd0;
            end else if (rx_valid && !rx_byte.parity_ok) begin
                idx_q <= 2'd0;                               // a corrupt byte drops the packet.
            end else if (accept) begin
                case (idx_q)
                    2'd0: if (rx_byte.data[STAT_ALWAYS1]) idx_q <= 2'd1;  // resync point.
                    2'd1: idx_q <= 2'd2;
                    default: begin
                        idx_q     <= 2'd0;
                        pkt_valid <= 1'b1;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge CLK100_IN) begin
        if (accept) begin
            case (idx_q)
                2'd0: status_q <= rx_byte.data;
                2'd1: dx_q     <= rx_byte.data;
                default: pkt   <= '{status: status_q, dx: dx_q, dy: rx_byte.data};
            endcase
        end
    end

endmodule

/* mouse_position.sv */
`timescale 1ns/1ns

module mouse_position (
    input  logic                CLK100_IN,
    input  logic                rst_n,
    input  logic                pkt_valid,
    input  ps2_pkg::mouse_pkt_t pkt,
    output ps2_pkg::mouse_pos_t pos
);

    import ps2_pkg::*;

    coord_t x_next;
    coord_t y_next;

    // adds a 9-bit signed delta and clamps the result to 0..255.
    function automatic coord_t sat_add(input coord_t c, input logic sign, input ps2_byte_t d);
        logic signed [9:0] sum;
        sum = $signed({2'b00, c}) + $signed({sign, sign, d});
        if (sum < 0) begin
            return 8'h00;
        end else if (sum > 10'sd255) begin
            return 8'hFF;
        end
        return sum[7:0];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // per-axis update
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        x_next = pos.x;
        y_next = pos.y;
        if (!pkt.status[STAT_X_OVF]) begin
            x_next = sat_add(pos.x, pkt.status[STAT_X_SIGN], pkt.dx);
        end
        if (!pkt.status[STAT_Y_OVF]) begin
            y_next = sat_add(pos.y, pkt.status[STAT_Y_SIGN], pkt.dy);  // overflow keeps the axis.
        end
    end

    always_ff @(posedge CLK100_IN or negedge rst_n) begin
        if (!rst_n) begin
            pos <= '{x: POS_RESET, y: POS_RESET, left: 1'b0, right: 1'b0};
        end else if (pkt_valid) begin
            pos.x     <= x_next;
            pos.y     <= y_next;
            pos.left  <= pkt.status[STAT_LEFT];
            pos.right <= pkt.status[STAT_RIGHT];
        end
    end

endmodule

/* seg7_control.sv */
`timescale 1ns/1ns

module seg7_control #(
    parameter int REFRESH_CYCLES = 100000
) (
    input  logic                CLK100_IN,
    input  logic                rst_n,
    input  ps2_pkg::mouse_pos_t pos,
    output logic [3:0]          seg_select,
    output logic [7:0]          seg_hex
);

    import ps2_pkg::*;

    localparam int REF_W = $clog2(REFRESH_CYCLES + 1);

    logic [REF_W-1:0] refresh_cnt_q;
    logic [1:0]       digit_q;       // digit being lit, counts down from 3.
    hex_digit_t       nibble;
    logic [6:0]       segs_n;        // g..a, active low.

    always_ff @(posedge CLK100_IN or negedge rst_n) begin
        if (!rst_n) begin
            refresh_cnt_q <= '0;
            digit_q       <= 2'd3;
        end else if (refresh_cnt_q == REF_W'(REFRESH_CYCLES - 1)) begin
            refresh_cnt_q <= '0;
            digit_q       <= digit_q - 2'd1;  // wraps from 0 back to 3.
        end else begin
            refresh_cnt_q <= refresh_cnt_q + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // digit mux and decode
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (digit_q)
            2'd3:    nibble = pos.x[7:4];
            2'd2:    nibble = pos.x[3:0];
            2'd1:    nibble = pos.y[7:4];
            default: nibble = pos.y[3:0];
        endcase
    end

    always_comb begin
        case (nibble)
            4'h0:    segs_n = 7'b1000000;
            4'h1:    segs_n = 7'b1111001;
            4'h2:    segs_n = 7'b0100100;
            4'h3:    segs_n = 7'b0110000;
            4'h4:    segs_n = 7'b0011001;
            4'h5:    segs_n = 7'b0010010;
            4'h6:    segs_n = 7'b0000010;
            4'h7:    segs_n = 7'b1111000;
            4'h8:    segs_n = 7'b0000000;
            4'h9:    segs_n = 7'b0010000;
            4'hA:    segs_n = 7'b0001000;
            4'hB:    segs_n = 7'b0000011;
            4'hC:    segs_n = 7'b1000110;
            4'hD:    segs_n = 7'b0100001;
            4'hE:    segs_n = 7'b0000110;
            default: segs_n = 7'b0001110;
        endcase
    end

    assign seg_select = ~(4'b0001 << digit_q);  // exactly one anode low.
    assign seg_hex    = {1'b1, segs_n};          // decimal point stays dark.

endmodule

/* top.sv */
`timescale 1ns/1ns

module top #(
    parameter int INHIBIT_CYCLES = 10000,
    parameter int REFRESH_CYCLES = 100000
) (
    input  logic       CLK100_IN,
    input  logic       arst_n,
    inout  wire        ps2_clk,
    inout  wire        ps2_data,
    output logic [3:0] seg_select,
    output logic [7:0] seg_hex,
    output logic       led_left,
    output logic       led_right,
    output logic       led_init_done,
    output logic [2:0] led_state
);

    import ps2_pkg::*;

    logic [1:0]  rst_sync_q;
    logic        rst_n;
    logic        clk_drive_low;
    logic        data_drive_low;
    logic        clk_fall;
    logic        data_sync;
    logic        rx_enable;
    logic        rx_valid;
    rx_byte_t    rx_byte;
    logic        init_done;
    init_state_e init_state;
    logic        pkt_valid;
    mouse_pkt_t  pkt;
    mouse_pos_t  pos;

    // ~~~~~~~~~~~~~~~~~~~~
    // reset and pads
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge CLK100_IN or negedge arst_n) begin
        if (!arst_n) begin
            rst_sync_q <= 2'b00;
        end else begin
            rst_sync_q <= {rst_sync_q[0], 1'b1};  // release lands two edges later.
        end
    end
    assign rst_n = rst_sync_q[1];

    assign ps2_clk  = clk_drive_low  ? 1'b0 : 1'bz;  // open drain, the board pulls up.
    assign ps2_data = data_drive_low ? 1'b0 : 1'bz;

    // ~~~~~~~~~~~~~~~~~~~~
    // stages
    // ~~~~~~~~~~~~~~~~~~~~
    ps2_frame_rx u_frame_rx (
        .CLK100_IN (CLK100_IN), .rst_n (rst_n),
        .ps2_clk_in (ps2_clk), .ps2_data_in (ps2_data), .rx_enable (rx_enable),
        .clk_fall (clk_fall), .data_sync (data_sync),
        .rx_valid (rx_valid), .rx_byte (rx_byte)
    );

    ps2_mouse_init #(.INHIBIT_CYCLES (INHIBIT_CYCLES)) u_mouse_init (
        .CLK100_IN (CLK100_IN), .rst_n (rst_n),
        .clk_fall (clk_fall), .data_sync (data_sync),
        .rx_valid (rx_valid), .rx_byte (rx_byte),
        .clk_drive_low (clk_drive_low), .data_drive_low (data_drive_low),
        .rx_enable (rx_enable), .init_done (init_done), .state (init_state)
    );

    ps2_packet_asm u_packet_asm (
        .CLK100_IN (CLK100_IN), .rst_n (rst_n), .init_done (init_done),
        .rx_valid (rx_valid), .rx_byte (rx_byte), .pkt_valid (pkt_valid), .pkt (pkt)
    );

    mouse_position u_position (
        .CLK100_IN (CLK100_IN), .rst_n (rst_n),
        .pkt_valid (pkt_valid), .pkt (pkt), .pos (pos)
    );

    seg7_control #(.REFRESH_CYCLES (REFRESH_CYCLES)) u_seg7 (
        .CLK100_IN (CLK100_IN), .rst_n (rst_n), .pos (pos),
        .seg_select (seg_select), .seg_hex (seg_hex)
    );

    assign led_left      = pos.left;
    assign led_right     = pos.right;
    assign led_init_done = init_done;
    assign led_state     = init_state;

endmodule

/* top_checker.sv */
`timescale 1ns/1ns

module top_checker (
    input logic                 CLK100_IN,
    input logic                 rst_n,
    input logic [3:0]           seg_select,
    input logic                 led_init_done,
    input logic                 init_done,
    input logic                 pkt_valid,
    input logic                 clk_drive_low,
    input logic                 data_drive_low,
    input ps2_pkg::init_state_e init_state
);

    import ps2_pkg::*;

    // digits light in the order 3, 2, 1, 0 with a single anode low.
    a_one_digit: assert property (@(posedge CLK100_IN) disable iff (!rst_n)
        $onehot(~seg_select) && (seg_select == $past(seg_select)
            || seg_select == {$past(seg_select[0]), $past(seg_select[3:1])}))
        else $error("seg_select is not a single low bit stepping through the digits");

    // init_done only rises, the mouse stays in stream mode.
    a_init_held: assert property (@(posedge CLK100_IN) disable iff (!rst_n)
        led_init_done |=> led_init_done)
        else $error("led_init_done fell outside reset");

    a_pkt_after_init: assert property (@(posedge CLK100_IN) disable iff (!rst_n)
        pkt_valid |-> init_done)
        else $error("pkt_valid while init_done is low");

    // data is pulled low under a held clock only for the request to send.
    a_drive_overlap: assert property (@(posedge CLK100_IN) disable iff (!rst_n)
        (clk_drive_low && data_drive_low) |-> init_state == INIT_REQUEST)
        else $error("both PS/2 lines driven low outside the request phase");

endmodule

/* tb_ps2_device.sv */
`timescale 1ns/1ns

module tb_ps2_device #(
    parameter int HALF_NS = 400
) (
    inout  wire                ps2_clk,
    inout  wire                ps2_data,
    output ps2_pkg::ps2_byte_t cmd_byte,
    output logic               cmd_parity_ok,
    output int                 cmd_count,
    output logic               done
);

    import ps2_pkg::*;

    localparam int SKEW_NS = 5;   // keeps line changes away from the system clock edges.

    logic       clk_low  = 1'b0;
    logic       data_low = 1'b0;
    logic [9:0] rx_bits;
    ps2_byte_t  reply;

    assign ps2_clk  = clk_low  ? 1'b0 : 1'bz;  // open drain like the real mouse.
    assign ps2_data = data_low ? 1'b0 : 1'bz;

    // one device frame, lsb first; bad_parity flips the parity bit.
    task automatic send_byte(input ps2_byte_t b, input logic bad_parity);
        logic [10:0] frame;
        frame = {1'b1, (~^b) ^ bad_parity, b, 1'b0};
        #(SKEW_NS + 2);
        for (int i = 0; i < 11; i++) begin
            data_low = ~frame[i];
            #(HALF_NS);
            clk_low = 1'b1;                  // the host samples on this falling edge.
            #(HALF_NS);
            clk_low = 1'b0;
        end
        data_low = 1'b0;
        #(2 * HALF_NS);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // host command handling
    // ~~~~~~~~~~~~~~~~~~~~
    initial begin
        cmd_byte      = '0;
        cmd_parity_ok = 1'b0;
        cmd_count     = 0;
        done          = 1'b0;
        reply         = '0;
        while (reply != RSP_ACK) begin
            wait (ps2_clk === 1'b0);                        // host inhibits the bus.
            wait (ps2_clk === 1'b1 && ps2_data === 1'b0);   // request to send.
            #(HALF_NS + SKEW_NS);
            for (int i = 0; i < 10; i++) begin
                clk_low = 1'b1;
                #(HALF_NS);
                clk_low = 1'b0;
                #(HALF_NS / 2);
                rx_bits[i] = ps2_data;                      // data bits, parity, stop.
                #(HALF_NS / 2);
            end
            data_low = 1'b1;                                // acknowledge bit.
            #(HALF_NS / 2);
            clk_low = 1'b1;
            #(HALF_NS);
            clk_low = 1'b0;
            #(HALF_NS);
            data_low      = 1'b0;
            cmd_byte      = rx_bits[7:0];
            cmd_parity_ok = (^rx_bits[8:0]) & rx_bits[9];
            cmd_count++;
            reply = (cmd_count == 1) ? 8'hFE : RSP_ACK;     // the first attempt is refused.
            #(2 * HALF_NS);
            send_byte(reply, 1'b0);
        end
        done = 1'b1;
    end

endmodule

/* tb_top.sv */
`timescale 1ns/1ns

module tb_top;

    import ps2_pkg::*;

    localparam int INHIBIT   = 200;
    localparam int REFRESH   = 16;
    localparam int BIT_CYC   = 40;              // device clock period in system cycles.
    localparam int FRAME_CYC = 11 * BIT_CYC;
    localparam int LIMIT     = (INHIBIT + 4 * FRAME_CYC
                               + 40 * (3 * FRAME_CYC + 4 * REFRESH)) * 3 / 2;

    logic       CLK100_IN = 1'b0;
    logic       arst_n    = 1'b0;
    wire        ps2_clk;
    wire        ps2_data;
    logic [3:0] seg_select;
    logic [7:0] seg_hex;
    logic       led_left;
    logic       led_right;
    logic       led_init_done;
    logic [2:0] led_state;
    ps2_byte_t  cmd_byte;
    logic       cmd_parity_ok;
    int         cmd_count;
    logic       dev_done;
    coord_t     disp_x    = '0;                 // position as read back from the display.
    coord_t     disp_y    = '0;
    mouse_pos_t exp_pos;
    integer     seed      = 90;
    int         cycle_cnt = 0;

    pullup (ps2_clk);
    pullup (ps2_data);

    top #(.INHIBIT_CYCLES (INHIBIT), .REFRESH_CYCLES (REFRESH)) u_dut (
        .CLK100_IN (CLK100_IN), .arst_n (arst_n), .ps2_clk (ps2_clk), .ps2_data (ps2_data),
        .seg_select (seg_select), .seg_hex (seg_hex), .led_left (led_left),
        .led_right (led_right), .led_init_done (led_init_done), .led_state (led_state)
    );

    tb_ps2_device u_dev (
        .ps2_clk (ps2_clk), .ps2_data (ps2_data), .cmd_byte (cmd_byte),
        .cmd_parity_ok (cmd_parity_ok), .cmd_count (cmd_count), .done (dev_done)
    );

    bind top top_checker u_checker (
        .CLK100_IN (CLK100_IN), .rst_n (rst_n), .seg_select (seg_select),
        .led_init_done (led_init_done), .init_done (init_done), .pkt_valid (pkt_valid),
        .clk_drive_low (clk_drive_low), .data_drive_low (data_drive_low),
        .init_state (init_state)
    );

    initial begin
        forever #10 CLK100_IN = ~CLK100_IN;
    end

    always @(posedge CLK100_IN) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= LIMIT) begin
            abort_run("timeout: the DUT did not finish the tests in time");
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // compare tasks
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic check_coord(input string name, input coord_t exp, input coord_t act);
        if (act !== exp) abort_run($sformatf("Fail %s: expected 0x%h, got 0x%h", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) abort_run($sformatf("Fail %s: expected 0x%h, got 0x%h", name, exp, act));
    endtask

    task automatic check_byte(input string name, input ps2_byte_t exp, input ps2_byte_t act);
        if (act !== exp) abort_run($sformatf("Fail %s: expected 0x%h, got 0x%h", name, exp, act));
    endtask

    task automatic check_state(input init_state_e exp, input logic [2:0] act);
        if (act !== exp) begin
            abort_run($sformatf("Fail led_state: expected 0x%h, got 0x%h", exp, act));
        end
    endtask

    // the next position as the mouse rules define it.
    function automatic mouse_pos_t ref_next_pos(input mouse_pos_t p, input mouse_pkt_t k);
        mouse_pos_t n;
        int         sx;
        int         sy;
        n       = p;
        n.left  = k.status[0];
        n.right = k.status[1];
        sx = int'(p.x) + int'(k.dx) - (k.status[4] ? 256 : 0);
        sy = int'(p.y) + int'(k.dy) - (k.status[5] ? 256 : 0);
        if (!k.status[6]) n.x = (sx < 0) ? 8'h00 : (sx > 255) ? 8'hFF : coord_t'(sx);
        if (!k.status[7]) n.y = (sy < 0) ? 8'h00 : (sy > 255) ? 8'hFF : coord_t'(sy);
        return n;
    endfunction

    // active-high segments g..a back to the digit value, -1 when unknown.
    function automatic int seg_value(input logic [6:0] lit);
        case (lit)
            7'h3F:   return 0;
            7'h06:   return 1;
            7'h5B:   return 2;
            7'h4F:   return 3;
            7'h66:   return 4;
            7'h6D:   return 5;
            7'h7D:   return 6;
            7'h07:   return 7;
            7'h7F:   return 8;
            7'h6F:   return 9;
            7'h77:   return 10;
            7'h7C:   return 11;
            7'h39:   return 12;
            7'h5E:   return 13;
            7'h79:   return 14;
            7'h71:   return 15;
            default: return -1;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // display decoder
    // ~~~~~~~~~~~~~~~~~~~~
    always @(negedge CLK100_IN) begin
        int v;
        if (arst_n) begin
            v = seg_value(~seg_hex[6:0]);
            if (v < 0 || seg_hex[7] !== 1'b1) begin
                abort_run($sformatf("the display shows an unknown pattern 0x%h", seg_hex));
            end
            case (seg_select)
                4'b0111: disp_x[7:4] = 4'(v);
                4'b1011: disp_x[3:0] = 4'(v);
                4'b1101: disp_y[7:4] = 4'(v);
                4'b1110: disp_y[3:0] = 4'(v);
                default: ;
            endcase
        end
    end

    // waits a full refresh round, then compares the display and the button LEDs.
    task automatic check_display();
        repeat (4 * REFRESH + 2) @(posedge CLK100_IN);
        check_coord("x", exp_pos.x, disp_x);
        check_coord("y", exp_pos.y, disp_y);
        check_bit("led_left", exp_pos.left, led_left);
        check_bit("led_right", exp_pos.right, led_right);
    endtask

    task automatic send_packet(input mouse_pkt_t k);
        u_dev.send_byte(k.status, 1'b0);
        u_dev.send_byte(k.dx, 1'b0);
        u_dev.send_byte(k.dy, 1'b0);
        exp_pos = ref_next_pos(exp_pos, k);
        check_display();
    endtask

    initial begin
        mouse_pkt_t k;
        exp_pos = '{x: POS_RESET, y: POS_RESET, left: 1'b0, right: 1'b0};
        repeat (8) @(posedge CLK100_IN);
        arst_n <= 1'b1;
        @(negedge CLK100_IN);
        check_state(INIT_IDLE, led_state);
        check_bit("led_init_done", 1'b0, led_init_done);
        check_bit("ps2_clk", 1'b1, ps2_clk);          // both pads released.
        check_bit("ps2_data", 1'b1, ps2_data);
        check_display();

        // the first command is refused with 0xFE, the retry gets 0xFA.
        wait (led_init_done === 1'b1 && dev_done === 1'b1);
        @(posedge CLK100_IN);
        check_byte("cmd_byte", CMD_ENABLE_STREAM, cmd_byte);
        check_bit("cmd_parity_ok", 1'b1, cmd_parity_ok);
        check_state(INIT_STREAM, led_state);
        if (cmd_count != 2) abort_run("the refused command was not sent a second time");

        for (int i = 0; i < 30; i++) begin
            k.status = {2'b00, 2'($random(seed)), 1'b1, 1'b0, 2'($random(seed))};
            k.dx     = 8'($random(seed));
            k.dy     = 8'($random(seed));
            send_packet(k);
        end

        k = {8'h38, 8'h80, 8'h80};                    // -128 on both axes.
        repeat (3) send_packet(k);
        check_coord("x", 8'h00, disp_x);
        check_coord("y", 8'h00, disp_y);
        k = {8'h08, 8'h7F, 8'h7F};
        repeat (3) send_packet(k);
        check_coord("x", 8'hFF, disp_x);
        check_coord("y", 8'hFF, disp_y);

        send_packet({8'h78, 8'h40, 8'hE0});           // x overflow, y moves by -32.
        check_coord("x", 8'hFF, disp_x);
        send_packet({8'h98, 8'hF0, 8'h10});           // y overflow, x moves by -16.
        check_coord("y", 8'hDF, disp_y);

        u_dev.send_byte(8'h08, 1'b0);
        u_dev.send_byte(8'h10, 1'b1);                 // corrupt dx ends this packet.
        check_display();
        send_packet({8'h09, 8'h05, 8'h03});

        u_dev.send_byte(8'h01, 1'b0);                 // bit 3 clear, not a status byte.
        send_packet({8'h3A, 8'hFE, 8'hFD});

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* vlog.f */
ps2_pkg.sv
ps2_frame_rx.sv
ps2_mouse_init.sv
ps2_packet_asm.sv
mouse_position.sv
seg7_control.sv
top.sv
top_checker.sv
tb_ps2_device.sv
tb_top.sv

/* Bender.yml */
package:
  name: ps2_mouse

sources:
  - files:
      - ps2_pkg.sv
      - ps2_frame_rx.sv
      - ps2_mouse_init.sv
      - ps2_packet_asm.sv
      - mouse_position.sv
      - seg7_control.sv
      - top.sv
  - target: test
    files:
      - top_checker.sv
      - tb_ps2_device.sv
      - tb_top.sv
